/* dcache.f */
+incdir+include
hdl/dcache_pkg.sv
hdl/dcache_arrays.sv
hdl/dcache_lookup.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
test/l2_model.sv
test/dcache_tb.sv

/* Makefile */
# Verilator build and run of the data cache testbench

SIM = obj_dir/dcache_sim

compile:
	verilator --binary --timing --assert -j 0 --top-module dcache_tb -f dcache.f -o dcache_sim

run: compile
	./$(SIM)

clean:
	rm -rf obj_dir

.PHONY: compile run clean

/* test/dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_tb;

    localparam int reset_cycles = 10;
    localparam int random_ops   = 40;
    localparam int op_budget    = 40;   // cycles allowed per access

    // set 0x10 holds A B C, set 0x20 holds D E F, set 0x30 holds G
    localparam logic [`DC_ADDR_W-1:0] addr_a = 32'h0000_1100;
    localparam logic [`DC_ADDR_W-1:0] addr_b = 32'h0000_2100;
    localparam logic [`DC_ADDR_W-1:0] addr_c = 32'h0000_3100;
    localparam logic [`DC_ADDR_W-1:0] addr_d = 32'h0000_4200;
    localparam logic [`DC_ADDR_W-1:0] addr_e = 32'h0000_5200;
    localparam logic [`DC_ADDR_W-1:0] addr_f = 32'h0000_6200;
    localparam logic [`DC_ADDR_W-1:0] addr_g = 32'h0000_7300;

    typedef struct packed {
        logic                  write;
        logic [`DC_ADDR_W-1:0] addr;
        logic [`DC_WORD_W-1:0] wdata;
        logic [`DC_WORD_W-1:0] rdata;     // checked on reads only
        logic [3:0]            l2_rd;     // line reads expected
        logic [3:0]            l2_wr;     // write backs expected
        logic [3:0]            cycles;    // 0 leaves latency open
        logic [`DC_ADDR_W-1:0] wb_addr;   // line written back
    } step_t;

    logic                  clk_tmp = 1'b0;
    logic                  rst_n;
    dcache_pkg::cpu_req_t  cpu_req;
    dcache_pkg::cpu_rsp_t  cpu_rsp;
    dcache_pkg::l2_req_t   l2_req;
    dcache_pkg::l2_rsp_t   l2_rsp;

    step_t                 steps[$];
    logic [`DC_WORD_W-1:0] shadow [logic [`DC_ADDR_W-1:0]];   // cpu writes by word address
    int                    cycle_count = 0;
    int                    cycle_limit = 0;

    always #5 clk_tmp = ~clk_tmp;

    dcache_top dut_i (
        .clk_tmp(clk_tmp),
        .rst_n  (rst_n),
        .cpu_req(cpu_req),
        .cpu_rsp(cpu_rsp),
        .l2_req (l2_req),
        .l2_rsp (l2_rsp)
    );

    l2_model l2_i (
        .clk_tmp(clk_tmp),
        .rst_n  (rst_n),
        .l2_req (l2_req),
        .l2_rsp (l2_rsp)
    );

    always @(posedge clk_tmp) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles with no completed run", cycle_limit);
            $display("Result: FAILED");
            $fatal(1);
        end
    end

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    function automatic logic [`DC_WORD_W-1:0] rule_word(input logic [`DC_ADDR_W-1:0] addr);
        return {addr[31:2], 2'b00} ^ 32'hA5A5_0000;
    endfunction

    function automatic logic [`DC_WORD_W-1:0] shadow_word(input logic [`DC_ADDR_W-1:0] addr);
        logic [`DC_ADDR_W-1:0] key;
        key = {addr[31:2], 2'b00};
        if (shadow.exists(key)) begin
            return shadow[key];
        end
        return rule_word(key);
    endfunction

    function automatic logic [`DC_LINE_W-1:0] shadow_line(input logic [`DC_ADDR_W-1:0] addr);
        logic [`DC_LINE_W-1:0] line;
        for (int w = 0; w < `DC_WORDS; w++) begin
            line[w*`DC_WORD_W +: `DC_WORD_W] = shadow_word({addr[31:4], 4'h0} + 32'(4 * w));
        end
        return line;
    endfunction

    task automatic add_step(input logic write, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [31:0] rdata, input int l2_rd, input int l2_wr,
                            input int cycles, input logic [31:0] wb_addr);
        step_t s;
        s = '{write: write, addr: addr, wdata: wdata, rdata: rdata, l2_rd: 4'(l2_rd),
              l2_wr: 4'(l2_wr), cycles: 4'(cycles), wb_addr: wb_addr};
        steps.push_back(s);
    endtask

    task automatic build_table();
        add_step(1'b0, addr_a,      32'h0,         rule_word(addr_a),      1, 0, 0, 32'h0);
        add_step(1'b0, addr_a + 8,  32'h0,         rule_word(addr_a + 8),  0, 0, 2, 32'h0);
        add_step(1'b1, addr_a + 4,  32'hDEAD_0001, 32'h0,                  0, 0, 3, 32'h0);
        add_step(1'b0, addr_a + 4,  32'h0,         32'hDEAD_0001,          0, 0, 2, 32'h0);
        add_step(1'b0, addr_a,      32'h0,         rule_word(addr_a),      0, 0, 2, 32'h0);
        add_step(1'b0, addr_a + 12, 32'h0,         rule_word(addr_a + 12), 0, 0, 2, 32'h0);
        add_step(1'b0, addr_b,      32'h0,         rule_word(addr_b),      1, 0, 0, 32'h0);
        add_step(1'b1, addr_b + 12, 32'hBEEF_0003, 32'h0,                  0, 0, 3, 32'h0);
        // both ways dirty so C evicts the older A
        add_step(1'b0, addr_c + 8,  32'h0,         rule_word(addr_c + 8),  1, 1, 0, addr_a);
        add_step(1'b0, addr_a + 4,  32'h0,         32'hDEAD_0001,          1, 1, 0, addr_b);
        add_step(1'b0, addr_b + 12, 32'h0,         32'hBEEF_0003,          1, 0, 0, 32'h0);
        add_step(1'b0, addr_b,      32'h0,         rule_word(addr_b),      0, 0, 2, 32'h0);
        // lru order in set 0x20
        add_step(1'b0, addr_d,      32'h0,         rule_word(addr_d),      1, 0, 0, 32'h0);
        add_step(1'b0, addr_e,      32'h0,         rule_word(addr_e),      1, 0, 0, 32'h0);
        add_step(1'b0, addr_d + 4,  32'h0,         rule_word(addr_d + 4),  0, 0, 2, 32'h0);
        add_step(1'b0, addr_f,      32'h0,         rule_word(addr_f),      1, 0, 0, 32'h0);
        add_step(1'b0, addr_d + 8,  32'h0,         rule_word(addr_d + 8),  0, 0, 2, 32'h0);
        add_step(1'b0, addr_e,      32'h0,         rule_word(addr_e),      1, 0, 0, 32'h0);
        add_step(1'b1, addr_g + 8,  32'h1234_5678, 32'h0,                  1, 0, 0, 32'h0);
        add_step(1'b0, addr_g + 8,  32'h0,         32'h1234_5678,          0, 0, 2, 32'h0);
        add_step(1'b0, addr_g + 12, 32'h0,         rule_word(addr_g + 12), 0, 0, 2, 32'h0);
    endtask

    // one cpu access, entered and left 1 ns after a rising edge
    task automatic access(input logic write, input logic [31:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output int cycles);
        cpu_req = '{valid: 1'b1, write: write, addr: addr, wdata: wdata};
        cycles  = 0;
        do begin
            @(posedge clk_tmp);
            #1;
            cycles++;
            assert (cpu_rsp.stall) else report_mismatch("stall", 128'(cpu_rsp.stall), 128'(1));
        end while (!cpu_rsp.done);
        rdata = cpu_rsp.rdata;
        @(posedge clk_tmp);   // request still held through the done cycle
        #1;
        assert (!cpu_rsp.done) else report_mismatch("done", 128'(cpu_rsp.done), 128'(0));
        assert (!cpu_rsp.stall) else report_mismatch("stall", 128'(cpu_rsp.stall), 128'(0));
        cpu_req.valid = 1'b0;
    endtask

    task automatic apply_step(input step_t s);
        int                    rd_base;
        int                    wr_base;
        logic [`DC_LINE_W-1:0] wb_line;
        logic [`DC_WORD_W-1:0] rdata;
        int                    cycles;

        rd_base = l2_i.read_count;
        wr_base = l2_i.write_count;
        wb_line = shadow_line(s.wb_addr);   // dirty line as the cpu left it
        access(s.write, s.addr, s.wdata, rdata, cycles);
        if (s.write) begin
            shadow[{s.addr[31:2], 2'b00}] = s.wdata;
        end else begin
            assert (rdata == s.rdata) else report_mismatch("rdata", 128'(rdata), 128'(s.rdata));
        end
        assert (l2_i.read_count - rd_base == int'(s.l2_rd))
            else report_mismatch("l2 reads", 128'(l2_i.read_count - rd_base), 128'(s.l2_rd));
        assert (l2_i.write_count - wr_base == int'(s.l2_wr))
            else report_mismatch("l2 writes", 128'(l2_i.write_count - wr_base), 128'(s.l2_wr));
        if (s.cycles != 0) begin
            assert (cycles == int'(s.cycles))
                else report_mismatch("done latency", 128'(cycles), 128'(s.cycles));
        end
        if (s.l2_wr != 0) begin
            assert (l2_i.last_wr_addr == s.wb_addr)
                else report_mismatch("l2 write addr", 128'(l2_i.last_wr_addr), 128'(s.wb_addr));
            assert (l2_i.last_wr_line == wb_line)
                else report_mismatch("l2 write line", l2_i.last_wr_line, wb_line);
        end
    endtask

    initial begin
        logic                  write;
        logic [`DC_ADDR_W-1:0] addr;
        logic [`DC_WORD_W-1:0] wdata;
        logic [`DC_WORD_W-1:0] expected;
        logic [`DC_WORD_W-1:0] rdata;
        int                    cycles;

        void'($urandom(56658));
        rst_n   = 1'b0;
        cpu_req = '0;
        build_table();
        cycle_limit = (steps.size() + random_ops) * op_budget + reset_cycles;

        repeat (reset_cycles) @(posedge clk_tmp);
        #1;
        rst_n = 1'b1;
        @(posedge clk_tmp);
        #1;
        assert (!cpu_rsp.stall) else report_mismatch("stall", 128'(cpu_rsp.stall), 128'(0));
        assert (!cpu_rsp.done) else report_mismatch("done", 128'(cpu_rsp.done), 128'(0));
        assert (!l2_req.req) else report_mismatch("l2 req", 128'(l2_req.req), 128'(0));

        foreach (steps[i]) begin
            apply_step(steps[i]);
        end

        // three tags over two sets keep evicting dirty lines
        for (int i = 0; i < random_ops; i++) begin
            write    = 1'($urandom % 2);
            addr     = {20'h8 + 20'($urandom % 3), 8'h40 + 8'($urandom % 2),
                        2'($urandom % 4), 2'b00};
            wdata    = $urandom;
            expected = shadow_word(addr);
            access(write, addr, wdata, rdata, cycles);
            if (write) begin
                shadow[addr] = wdata;
            end else begin
                assert (rdata == expected)
                    else report_mismatch("random rdata", 128'(rdata), 128'(expected));
            end
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* test/l2_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module l2_model (
    input  logic                clk_tmp,
    input  logic                rst_n,
    input  dcache_pkg::l2_req_t l2_req,
    output dcache_pkg::l2_rsp_t l2_rsp
);

    localparam int AckDelay = 4;   // cycles from req rise to ack

    logic [`DC_WORD_W-1:0] mem [logic [`DC_ADDR_W-1:0]];   // only words written back
    logic [`DC_LINE_W-1:0] rd_line;
    logic                  ack_q = 1'b0;
    logic [`DC_LINE_W-1:0] rdata_q = '0;
    int                    wait_cnt = 0;
    int                    read_count = 0;      // line reads served
    int                    write_count = 0;     // line writes served
    logic [`DC_ADDR_W-1:0] last_wr_addr = '0;
    logic [`DC_LINE_W-1:0] last_wr_line = '0;

    function automatic logic [`DC_WORD_W-1:0] load_word(input logic [`DC_ADDR_W-1:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return addr ^ 32'hA5A5_0000;   // untouched memory follows the address
    endfunction

    always @(posedge clk_tmp) begin
        if (!rst_n) begin
            ack_q       <= 1'b0;
            wait_cnt    <= 0;
            read_count  <= 0;
            write_count <= 0;
        end else begin
            ack_q <= 1'b0;
            if (l2_req.req && !ack_q) begin
                if (wait_cnt == AckDelay - 1) begin
                    wait_cnt <= 0;
                    ack_q    <= 1'b1;
                    if (l2_req.write) begin
                        for (int w = 0; w < `DC_WORDS; w++) begin
                            mem[l2_req.addr + 32'(4 * w)] =
                                l2_req.wdata[w*`DC_WORD_W +: `DC_WORD_W];
                        end
                        last_wr_addr <= l2_req.addr;
                        last_wr_line <= l2_req.wdata;
                        write_count  <= write_count + 1;
                    end else begin
                        for (int w = 0; w < `DC_WORDS; w++) begin
                            rd_line[w*`DC_WORD_W +: `DC_WORD_W] =
                                load_word(l2_req.addr + 32'(4 * w));
                        end
                        rdata_q    <= rd_line;
                        read_count <= read_count + 1;
                    end
                end else begin
                    wait_cnt <= wait_cnt + 1;
                end
            end else begin
                wait_cnt <= 0;   // idle or ack cycle
            end
        end
    end

    assign l2_rsp = '{ack: ack_q, rdata: rdata_q};

endmodule

`default_nettype wire

/* hdl/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_top (
    input  logic                 clk_tmp,
    input  logic                 rst_n,
    input  dcache_pkg::cpu_req_t cpu_req,
    output dcache_pkg::cpu_rsp_t cpu_rsp,
    output dcache_pkg::l2_req_t  l2_req,
    input  dcache_pkg::l2_rsp_t  l2_rsp
);

    logic [`DC_INDEX_W-1:0] index;
    dcache_pkg::way_fill_t  fill;
    logic                   touch;
    logic                   touch_way;
    logic [`DC_TAG_W-1:0]   tag0;
    logic [`DC_TAG_W-1:0]   tag1;
    logic                   valid0;
    logic                   valid1;
    logic                   dirty0;
    logic                   dirty1;
    logic [`DC_LINE_W-1:0]  line0;
    logic [`DC_LINE_W-1:0]  line1;
    logic                   lru;
    dcache_pkg::lookup_t    result;
    logic [`DC_WORD_W-1:0]  rword;
    logic [`DC_LINE_W-1:0]  merged_line;
    logic [`DC_TAG_W-1:0]   victim_tag;
    logic [`DC_LINE_W-1:0]  victim_line;

    assign index = cpu_req.addr[`DC_ADDR_W-`DC_TAG_W-1 -: `DC_INDEX_W];   // set of current access

    dcache_arrays arrays_i (
        .clk_tmp  (clk_tmp),
        .rst_n    (rst_n),
        .index    (index),
        .fill     (fill),
        .touch    (touch),
        .touch_way(touch_way),
        .tag0     (tag0),
        .tag1     (tag1),
        .valid0   (valid0),
        .valid1   (valid1),
        .dirty0   (dirty0),
        .dirty1   (dirty1),
        .line0    (line0),
        .line1    (line1),
        .lru      (lru)
    );

    dcache_lookup lookup_i (
        .addr       (cpu_req.addr),
        .wdata      (cpu_req.wdata),
        .tag0       (tag0),
        .tag1       (tag1),
        .valid0     (valid0),
        .valid1     (valid1),
        .dirty0     (dirty0),
        .dirty1     (dirty1),
        .line0      (line0),
        .line1      (line1),
        .lru        (lru),
        .result     (result),
        .rword      (rword),
        .merged_line(merged_line),
        .victim_tag (victim_tag),
        .victim_line(victim_line)
    );

    dcache_ctrl ctrl_i (
        .clk_tmp    (clk_tmp),
        .rst_n      (rst_n),
        .cpu_req    (cpu_req),
        .cpu_rsp    (cpu_rsp),
        .result     (result),
        .rword      (rword),
        .merged_line(merged_line),
        .victim_tag (victim_tag),
        .victim_line(victim_line),
        .fill       (fill),
        .touch      (touch),
        .touch_way  (touch_way),
        .l2_req     (l2_req),
        .l2_rsp     (l2_rsp)
    );

endmodule

`default_nettype wire

/* hdl/dcache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_ctrl (
    input  logic                   clk_tmp,
    input  logic                   rst_n,
    input  dcache_pkg::cpu_req_t   cpu_req,
    output dcache_pkg::cpu_rsp_t   cpu_rsp,
    input  dcache_pkg::lookup_t    result,
    input  logic [`DC_WORD_W-1:0]  rword,
    input  logic [`DC_LINE_W-1:0]  merged_line,
    input  logic [`DC_TAG_W-1:0]   victim_tag,
    input  logic [`DC_LINE_W-1:0]  victim_line,
    output dcache_pkg::way_fill_t  fill,
    output logic                   touch,
    output logic                   touch_way,
    output dcache_pkg::l2_req_t    l2_req,
    input  dcache_pkg::l2_rsp_t    l2_rsp
);

    localparam int LineLsb = `DC_ADDR_W - `DC_TAG_W - `DC_INDEX_W;

    dcache_pkg::dc_state_e  state_q;
    logic                   stall_q;
    logic                   done_q;
    logic [`DC_WORD_W-1:0]  rdata_q;
    logic                   fill_way_q;      // victim picked at the miss
    logic [`DC_LINE_W-1:0]  refill_q;        // line returned by L2
    logic                   l2_valid_q;
    logic                   l2_write_q;
    logic [`DC_ADDR_W-1:0]  l2_addr_q;
    logic [`DC_LINE_W-1:0]  l2_wdata_q;
    logic [`DC_TAG_W-1:0]   req_tag;
    logic [`DC_INDEX_W-1:0] req_index;
    logic [`DC_ADDR_W-1:0]  wb_addr;
    logic [`DC_ADDR_W-1:0]  fetch_addr;

    assign req_tag    = cpu_req.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign req_index  = cpu_req.addr[`DC_ADDR_W-`DC_TAG_W-1 -: `DC_INDEX_W];
    assign wb_addr    = {victim_tag, req_index, {LineLsb{1'b0}}};   // old line location
    assign fetch_addr = {req_tag, req_index, {LineLsb{1'b0}}};

    always_ff @(posedge clk_tmp) begin
        if (!rst_n) begin
            state_q    <= dcache_pkg::st_idle;
            stall_q    <= 1'b0;
            done_q     <= 1'b0;
            l2_valid_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                dcache_pkg::st_idle: begin
                    stall_q <= 1'b0;
                    if (cpu_req.valid && !done_q) begin   // request just finished is still up
                        stall_q <= 1'b1;
                        state_q <= dcache_pkg::st_lookup;
                    end
                end
                dcache_pkg::st_lookup: begin
                    if (result.hit) begin
                        if (cpu_req.write) begin
                            state_q <= dcache_pkg::st_write_hit;
                        end else begin
                            done_q  <= 1'b1;
                            state_q <= dcache_pkg::st_idle;
                        end
                    end else if (result.victim_valid && result.victim_dirty) begin
                        state_q <= dcache_pkg::st_write_back;
                    end else begin
                        state_q <= dcache_pkg::st_refill;
                    end
                end
                dcache_pkg::st_write_hit: begin
                    done_q  <= 1'b1;
                    state_q <= dcache_pkg::st_idle;
                end
                dcache_pkg::st_write_back: begin
                    if (!l2_valid_q) begin
                        l2_valid_q <= 1'b1;
                    end else if (l2_rsp.ack) begin
                        l2_valid_q <= 1'b0;
                        state_q    <= dcache_pkg::st_refill;
                    end
                end
                dcache_pkg::st_refill: begin
                    if (!l2_valid_q) begin
                        l2_valid_q <= 1'b1;
                    end else if (l2_rsp.ack) begin
                        l2_valid_q <= 1'b0;
                        state_q    <= dcache_pkg::st_fill;
                    end
                end
                dcache_pkg::st_fill: begin
                    state_q <= dcache_pkg::st_lookup;   // replay as a hit
                end
                default: begin
                    state_q <= dcache_pkg::st_idle;
                end
            endcase
        end
    end

    // data path registers
    always_ff @(posedge clk_tmp) begin
        case (state_q)
            dcache_pkg::st_lookup: begin
                rdata_q    <= rword;
                fill_way_q <= result.victim_way;
            end
            dcache_pkg::st_write_back: begin
                if (!l2_valid_q) begin
                    l2_write_q <= 1'b1;
                    l2_addr_q  <= wb_addr;
                    l2_wdata_q <= victim_line;
                end
            end
            dcache_pkg::st_refill: begin
                if (!l2_valid_q) begin
                    l2_write_q <= 1'b0;
                    l2_addr_q  <= fetch_addr;
                end else if (l2_rsp.ack) begin
                    refill_q <= l2_rsp.rdata;
                end
            end
            default: ;
        endcase
    end

    // array write and lru update
    always_comb begin
        fill       = '0;
        fill.index = req_index;
        fill.tag   = req_tag;
        touch      = 1'b0;
        touch_way  = result.hit_way;
        case (state_q)
            dcache_pkg::st_lookup: begin
                touch = result.hit && !cpu_req.write;   // load completes here
            end
            dcache_pkg::st_write_hit: begin
                fill.we    = 1'b1;
                fill.way   = result.hit_way;
                fill.dirty = 1'b1;
                fill.line  = merged_line;
                touch      = 1'b1;
            end
            dcache_pkg::st_fill: begin
                fill.we    = 1'b1;
                fill.way   = fill_way_q;
                fill.line  = refill_q;             // clean copy
                touch      = 1'b1;
                touch_way  = fill_way_q;
            end
            default: ;
        endcase
    end

    assign cpu_rsp = '{stall: stall_q, done: done_q, rdata: rdata_q};
    assign l2_req  = '{req: l2_valid_q, write: l2_write_q, addr: l2_addr_q, wdata: l2_wdata_q};

    a_done_no_l2: assert property (
        @(posedge clk_tmp) disable iff (!rst_n) $rose(done_q) |-> !l2_valid_q
    );

    a_l2_aligned: assert property (
        @(posedge clk_tmp) disable iff (!rst_n) l2_valid_q |-> (l2_addr_q[LineLsb-1:0] == '0)
    );

    a_l2_hold: assert property (
        @(posedge clk_tmp) disable iff (!rst_n)
        (l2_valid_q && !l2_rsp.ack) |=> (l2_valid_q && $stable(l2_write_q)
                                         && $stable(l2_addr_q) && $stable(l2_wdata_q))
    );

endmodule

`default_nettype wire

/* hdl/dcache_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_lookup (
    input  logic [`DC_ADDR_W-1:0] addr,
    input  logic [`DC_WORD_W-1:0] wdata,
    input  logic [`DC_TAG_W-1:0]  tag0,
    input  logic [`DC_TAG_W-1:0]  tag1,
    input  logic                  valid0,
    input  logic                  valid1,
    input  logic                  dirty0,
    input  logic                  dirty1,
    input  logic [`DC_LINE_W-1:0] line0,
    input  logic [`DC_LINE_W-1:0] line1,
    input  logic                  lru,
    output dcache_pkg::lookup_t   result,
    output logic [`DC_WORD_W-1:0] rword,
    output logic [`DC_LINE_W-1:0] merged_line,
    output logic [`DC_TAG_W-1:0]  victim_tag,
    output logic [`DC_LINE_W-1:0] victim_line
);

    logic [`DC_TAG_W-1:0]    addr_tag;
    logic [`DC_OFFSET_W-1:0] word_sel;
    logic                    hit0;
    logic                    hit1;
    logic                    victim;
    logic [`DC_LINE_W-1:0]   hit_line;

    assign addr_tag = addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign word_sel = addr[`DC_ADDR_W-`DC_TAG_W-`DC_INDEX_W-1 -: `DC_OFFSET_W];

    assign hit0 = valid0 && (tag0 == addr_tag);
    assign hit1 = valid1 && (tag1 == addr_tag);

    // empty way first, then the lru way
    always_comb begin
        if (!valid0) begin
            victim = 1'b0;
        end else if (!valid1) begin
            victim = 1'b1;
        end else begin
            victim = lru;
        end
    end

    assign hit_line    = hit0 ? line0 : line1;    // way 0 wins on a double match
    assign victim_tag  = victim ? tag1 : tag0;
    assign victim_line = victim ? line1 : line0;

    assign result = '{
        hit:          hit0 | hit1,
        hit_way:      ~hit0,
        victim_way:   victim,
        victim_valid: victim ? valid1 : valid0,
        victim_dirty: victim ? dirty1 : dirty0
    };

    // word select and store merge
    always_comb begin
        rword       = hit_line[`DC_WORD_W-1:0];
        merged_line = hit_line;
        for (int w = 0; w < `DC_WORDS; w++) begin
            if (int'(word_sel) == w) begin
                rword = hit_line[w*`DC_WORD_W +: `DC_WORD_W];
                merged_line[w*`DC_WORD_W +: `DC_WORD_W] = wdata;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/dcache_arrays.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_arrays (
    input  logic                   clk_tmp,
    input  logic                   rst_n,
    input  logic [`DC_INDEX_W-1:0] index,      // lookup set
    input  dcache_pkg::way_fill_t  fill,
    input  logic                   touch,
    input  logic                   touch_way,
    output logic [`DC_TAG_W-1:0]   tag0,
    output logic [`DC_TAG_W-1:0]   tag1,
    output logic                   valid0,
    output logic                   valid1,
    output logic                   dirty0,
    output logic                   dirty1,
    output logic [`DC_LINE_W-1:0]  line0,
    output logic [`DC_LINE_W-1:0]  line1,
    output logic                   lru
);

    // storage indexed [way][set]
    logic [`DC_TAG_W-1:0]  tag_mem  [2][`DC_SETS];
    logic [`DC_LINE_W-1:0] line_mem [2][`DC_SETS];

    logic [1:0][`DC_SETS-1:0] valid_q;
    logic [1:0][`DC_SETS-1:0] dirty_q;
    logic [`DC_SETS-1:0]      lru_q;     // way to replace next

    always_ff @(posedge clk_tmp) begin
        if (fill.we) begin
            tag_mem[fill.way][fill.index]  <= fill.tag;
            line_mem[fill.way][fill.index] <= fill.line;
        end
    end

    always_ff @(posedge clk_tmp) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill.we) begin
            valid_q[fill.way][fill.index] <= 1'b1;
            dirty_q[fill.way][fill.index] <= fill.dirty;   // set on write hit, clear on refill
        end
    end

    always_ff @(posedge clk_tmp) begin
        if (!rst_n) begin
            lru_q <= '0;
        end else if (touch) begin
            lru_q[index] <= ~touch_way;    // other way becomes oldest
        end
    end

    // combinational read of the addressed set
    assign tag0   = tag_mem[0][index];
    assign tag1   = tag_mem[1][index];
    assign line0  = line_mem[0][index];
    assign line1  = line_mem[1][index];
    assign valid0 = valid_q[0][index];
    assign valid1 = valid_q[1][index];
    assign dirty0 = dirty_q[0][index];
    assign dirty1 = dirty_q[1][index];
    assign lru    = lru_q[index];

    a_fill_way_known: assert property (
        @(posedge clk_tmp) disable iff (!rst_n)
        fill.we |-> !$isunknown({fill.way, fill.index})
    );

endmodule

`default_nettype wire

/* hdl/dcache_pkg.sv */
`default_nettype none

`include "dcache_defs.svh"

package dcache_pkg;

    typedef struct packed {
        logic                  valid;   // access request level
        logic                  write;   // 1 store, 0 load
        logic [`DC_ADDR_W-1:0] addr;
        logic [`DC_WORD_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                  stall;   // busy with a request
        logic                  done;    // one cycle completion pulse
        logic [`DC_WORD_W-1:0] rdata;   // valid with done on a load
    } cpu_rsp_t;

    typedef struct packed {
        logic                  req;     // held until ack
        logic                  write;   // line write back
        logic [`DC_ADDR_W-1:0] addr;    // line aligned
        logic [`DC_LINE_W-1:0] wdata;
    } l2_req_t;

    typedef struct packed {
        logic                  ack;     // one cycle pulse
        logic [`DC_LINE_W-1:0] rdata;
    } l2_rsp_t;

    // array write command
    typedef struct packed {
        logic                   we;
        logic                   way;
        logic [`DC_INDEX_W-1:0] index;
        logic [`DC_TAG_W-1:0]   tag;
        logic                   dirty;
        logic [`DC_LINE_W-1:0]  line;
    } way_fill_t;

    typedef struct packed {
        logic hit;
        logic hit_way;
        logic victim_way;
        logic victim_valid;
        logic victim_dirty;
    } lookup_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_write_hit,
        st_write_back,
        st_refill,
        st_fill
    } dc_state_e;

endpackage

`default_nettype wire

/* include/dcache_defs.svh */
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// data cache geometry
// 2 ways, 256 sets, 16 byte lines
// address layout  tag [31:12] | index [11:4] | word [3:2] | byte [1:0]

`define DC_ADDR_W    32   // cpu byte address
`define DC_TAG_W     20   // addr[31:12]
`define DC_INDEX_W   8    // addr[11:4]
`define DC_SETS      256  // 2**DC_INDEX_W
`define DC_OFFSET_W  2    // addr[3:2], word within line

// payload sizes
`define DC_WORD_W    32   // cpu word
`define DC_LINE_W    128  // one cache line, also the L2 transfer unit
`define DC_WORDS     4    // words per line

// byte offset addr[1:0] is not decoded
// a line address has the low
// DC_ADDR_W - DC_TAG_W - DC_INDEX_W bits cleared

`endif
